/* rv_core.f */
+incdir+include
verilog/rv_pkg.sv
verilog/rv_decode.sv
verilog/rv_alu.sv
verilog/rv_regfile.sv
verilog/rv_core.sv
sim/rv_core_checker.sv
sim/rv_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= rv_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard verilog/*.sv sim/*.sv include/*.svh)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/rv_core_tb.sv */
`timescale 1ns/10ps
`include "rv_core_config.svh"

module rv_core_tb
  import rv_pkg::*;
();

  localparam int MAX_ENTRIES = 64;
  localparam int MAX_CYCLES = 200;

  // one program word with what it must do
  typedef struct packed {
    logic [8*16-1:0]     name;
    logic [31:0]         insn;
    wb_t                 exp_wb;
    logic                exp_halt;
    logic [`RV_XLEN-1:0] exp_pc;
    logic                skipped;
  } entry_t;

  logic                clk;
  logic                rst;
  logic                active;
  logic [`RV_XLEN-1:0] pc;
  logic [31:0]         insn;
  wb_t                 wb;
  logic                halt;
  int                  pass_count;
  int                  fail_count;
  entry_t              table_mem [MAX_ENTRIES];
  int                  num_entries;
  entry_t              cur;

  rv_core u_dut (
    .clk  (clk),
    .rst  (rst),
    .pc   (pc),
    .insn (insn),
    .wb   (wb),
    .halt (halt)
  );

  rv_core_checker u_check (
    .clk        (clk),
    .rst        (rst),
    .active     (active),
    .pc         (pc),
    .wb         (wb),
    .halt       (halt),
    .name       (cur.name),
    .exp_wb     (cur.exp_wb),
    .exp_halt   (cur.exp_halt),
    .exp_pc     (cur.exp_pc),
    .skipped    (cur.skipped),
    .pass_count (pass_count),
    .fail_count (fail_count)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // RV32I instruction formats
  function automatic logic [31:0] imm_op(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] reg_op(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] branch_insn(logic [12:0] off, logic [4:0] rs2,
                                              logic [4:0] rs1, logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] upper_imm(logic [19:0] imm, logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  task automatic append_entry(input logic [8*16-1:0] name, input logic [31:0] insn_word,
                              input wb_t w, input logic h, input logic [31:0] step,
                              input logic skip);
    entry_t e;
    e.name = name;
    e.insn = insn_word;
    e.exp_wb = w;
    e.exp_halt = h;
    e.exp_pc = num_entries * `RV_INSN_BYTES + step;
    e.skipped = skip;
    table_mem[num_entries] = e;
    num_entries++;
  endtask

  task automatic write_entry(input logic [8*16-1:0] name, input logic [31:0] insn_word,
                             input logic [4:0] rd, input logic [31:0] data);
    append_entry(name, insn_word, {1'b1, rd, data}, 1'b0, 32'd4, 1'b0);
  endtask

  task automatic quiet_entry(input logic [8*16-1:0] name, input logic [31:0] insn_word,
                             input logic h);
    append_entry(name, insn_word, '0, h, 32'd4, 1'b0);
  endtask

  // a taken branch jumps over the word that follows it
  task automatic taken_branch(input logic [8*16-1:0] name, input logic [31:0] insn_word);
    append_entry(name, insn_word, '0, 1'b0, 32'd8, 1'b0);
    append_entry("skipped", imm_op(12'hfff, 5'd0, 3'b000, 5'd31), {1'b1, 5'd31, 32'hffffffff},
                 1'b0, 32'd4, 1'b1);
  endtask

  function automatic entry_t fetch(input logic [`RV_XLEN-1:0] addr);
    entry_t e;
    int idx;
    idx = int'(addr >> 2);
    if (addr[1:0] == 2'b00 && idx < num_entries) begin
      e = table_mem[idx];
    end else begin
      e = '0;
      e.name = "past the end";
      e.skipped = 1'b1;
    end
    return e;
  endfunction

  // instruction port model
  always @(posedge clk) begin
    #1;
    cur = fetch(pc);
  end

  assign insn = cur.insn;

  initial begin
    int   cycles;
    logic halted;
    num_entries = 0;
    write_entry("lui x1", upper_imm(20'h80000, 5'd1), 5'd1, 32'h80000000);
    write_entry("addi neg", imm_op(12'hffb, 5'd0, 3'b000, 5'd2), 5'd2, 32'hfffffffb);
    write_entry("addi pos", imm_op(12'h007, 5'd0, 3'b000, 5'd3), 5'd3, 32'h00000007);
    write_entry("slti", imm_op(12'h003, 5'd2, 3'b010, 5'd4), 5'd4, 32'h00000001);
    write_entry("sltiu", imm_op(12'h003, 5'd2, 3'b011, 5'd5), 5'd5, 32'h00000000);
    write_entry("xori", imm_op(12'h0f0, 5'd3, 3'b100, 5'd6), 5'd6, 32'h000000f7);
    write_entry("ori", imm_op(12'hff0, 5'd3, 3'b110, 5'd7), 5'd7, 32'hfffffff7);
    write_entry("andi", imm_op(12'h0ff, 5'd2, 3'b111, 5'd8), 5'd8, 32'h000000fb);
    write_entry("slli", imm_op(12'h004, 5'd3, 3'b001, 5'd9), 5'd9, 32'h00000070);
    write_entry("srli", imm_op(12'h004, 5'd1, 3'b101, 5'd10), 5'd10, 32'h08000000);
    write_entry("srai", imm_op(12'h404, 5'd1, 3'b101, 5'd11), 5'd11, 32'hf8000000);
    write_entry("add", reg_op(7'h00, 5'd3, 5'd2, 3'b000, 5'd12), 5'd12, 32'h00000002);
    write_entry("sub under", reg_op(7'h20, 5'd3, 5'd0, 3'b000, 5'd13), 5'd13, 32'hfffffff9);
    // shift amount 35 only counts as 3
    write_entry("addi 35", imm_op(12'h023, 5'd0, 3'b000, 5'd14), 5'd14, 32'h00000023);
    write_entry("sll", reg_op(7'h00, 5'd14, 5'd3, 3'b001, 5'd15), 5'd15, 32'h00000038);
    write_entry("srl", reg_op(7'h00, 5'd14, 5'd1, 3'b101, 5'd16), 5'd16, 32'h10000000);
    write_entry("sra", reg_op(7'h20, 5'd14, 5'd1, 3'b101, 5'd17), 5'd17, 32'hf0000000);
    write_entry("slt", reg_op(7'h00, 5'd3, 5'd2, 3'b010, 5'd18), 5'd18, 32'h00000001);
    write_entry("sltu", reg_op(7'h00, 5'd3, 5'd2, 3'b011, 5'd19), 5'd19, 32'h00000000);
    write_entry("xor", reg_op(7'h00, 5'd3, 5'd2, 3'b100, 5'd20), 5'd20, 32'hfffffffc);
    write_entry("or", reg_op(7'h00, 5'd3, 5'd1, 3'b110, 5'd21), 5'd21, 32'h80000007);
    write_entry("and", reg_op(7'h00, 5'd6, 5'd2, 3'b111, 5'd22), 5'd22, 32'h000000f3);
    write_entry("write x0", imm_op(12'h005, 5'd3, 3'b000, 5'd0), 5'd0, 32'h0000000c);
    write_entry("read x0", reg_op(7'h00, 5'd3, 5'd0, 3'b000, 5'd23), 5'd23, 32'h00000007);
    write_entry("chain", imm_op(12'h001, 5'd23, 3'b000, 5'd24), 5'd24, 32'h00000008);
    taken_branch("beq taken", branch_insn(13'd8, 5'd23, 5'd3, 3'b000));
    quiet_entry("beq not", branch_insn(13'd8, 5'd2, 5'd3, 3'b000), 1'b0);
    taken_branch("bne taken", branch_insn(13'd8, 5'd2, 5'd3, 3'b001));
    quiet_entry("bne not", branch_insn(13'd8, 5'd23, 5'd3, 3'b001), 1'b0);
    taken_branch("blt taken", branch_insn(13'd8, 5'd3, 5'd2, 3'b100));
    quiet_entry("blt not", branch_insn(13'd8, 5'd2, 5'd3, 3'b100), 1'b0);
    taken_branch("bge taken", branch_insn(13'd8, 5'd2, 5'd3, 3'b101));
    quiet_entry("bge not", branch_insn(13'd8, 5'd3, 5'd2, 3'b101), 1'b0);
    taken_branch("bltu taken", branch_insn(13'd8, 5'd2, 5'd3, 3'b110));
    quiet_entry("bltu not", branch_insn(13'd8, 5'd3, 5'd2, 3'b110), 1'b0);
    taken_branch("bgeu taken", branch_insn(13'd8, 5'd3, 5'd2, 3'b111));
    quiet_entry("bgeu not", branch_insn(13'd8, 5'd2, 5'd3, 3'b111), 1'b0);
    quiet_entry("mul ignored", reg_op(7'h01, 5'd3, 5'd3, 3'b000, 5'd25), 1'b0);
    quiet_entry("ecall", 32'h00000073, 1'b1);
    write_entry("after ecall", imm_op(12'h000, 5'd0, 3'b000, 5'd0), 5'd0, 32'h00000000);

    cur = table_mem[0];
    rst = 1'b1;
    active = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    active = 1'b1;

    cycles = 0;
    halted = 1'b0;
    while (!halted && cycles < MAX_CYCLES) begin
      @(negedge clk);
      halted = halt;
      cycles++;
    end
    if (!halted) begin
      $display("timeout: halt never rose within %0d cycles", MAX_CYCLES);
    end
    // the checker still finishes ecall and the entry after it
    repeat (2) @(posedge clk);
    #3;
    $display("passed %0d failed %0d", pass_count, fail_count);
    if (halted && fail_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* sim/rv_core_checker.sv */
`timescale 1ns/10ps
`include "rv_core_config.svh"

module rv_core_checker
  import rv_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                active,
  input  logic [`RV_XLEN-1:0] pc,
  input  wb_t                 wb,
  input  logic                halt,
  input  logic [8*16-1:0]     name,
  input  wb_t                 exp_wb,
  input  logic                exp_halt,
  input  logic [`RV_XLEN-1:0] exp_pc,
  input  logic                skipped,
  output int                  pass_count,
  output int                  fail_count
);

  logic [8*16-1:0]     cur_name;
  logic [`RV_XLEN-1:0] cur_exp_pc;
  int                  errors;

  // wb and halt are sampled mid-cycle, the new pc just after the edge
  initial begin
    pass_count = 0;
    fail_count = 0;
    @(posedge clk);
    forever begin
      @(negedge clk);
      errors = 0;
      if (rst) begin
        if (pc !== '0 || wb.we !== 1'b0 || halt !== 1'b0) begin
          $display("reset state wrong: pc %h we %b halt %b", pc, wb.we, halt);
          fail_count++;
        end
      end else if (active) begin
        cur_name = name;
        cur_exp_pc = exp_pc;
        if (skipped) begin
          $display("%0s at pc %h was fetched but should never run", cur_name, pc);
          errors++;
        end
        if (wb.we !== exp_wb.we) begin
          $display("mismatch %0s we expected %b actual %b", cur_name, exp_wb.we, wb.we);
          errors++;
        end else if (exp_wb.we && (wb.rd !== exp_wb.rd || wb.data !== exp_wb.data)) begin
          $display("mismatch %0s rd/data expected x%0d/%h actual x%0d/%h",
                   cur_name, exp_wb.rd, exp_wb.data, wb.rd, wb.data);
          errors++;
        end
        if (halt !== exp_halt) begin
          $display("mismatch %0s halt expected %b actual %b", cur_name, exp_halt, halt);
          errors++;
        end
        @(posedge clk);
        #2;
        if (pc !== cur_exp_pc) begin
          $display("mismatch %0s next pc expected %h actual %h", cur_name, cur_exp_pc, pc);
          errors++;
        end
        if (errors == 0) begin
          $display("ok     %0s", cur_name);
          pass_count++;
        end else begin
          $display("failed %0s", cur_name);
          fail_count++;
        end
      end
    end
  end

endmodule

/* verilog/rv_core.sv */
`timescale 1ns/10ps
`include "rv_core_config.svh"

module rv_core
  import rv_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  output logic [`RV_XLEN-1:0] pc,
  input  logic [31:0]         insn,
  output wb_t                 wb,
  output logic                halt
);

  localparam logic [`RV_XLEN-1:0] RESET_PC = `RV_RESET_PC;
  localparam logic [`RV_XLEN-1:0] INSN_STEP = `RV_INSN_BYTES;

  decoded_t            dec;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic [`RV_XLEN-1:0] alu_b;
  logic [`RV_XLEN-1:0] alu_result;
  logic                branch_taken;
  logic [`RV_XLEN-1:0] pc_next;

  rv_decode u_decode (
    .insn (insn),
    .dec  (dec)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .wb       (wb),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // immediate forms use the decoded immediate as second operand
  assign alu_b = dec.use_imm ? dec.imm : rs2_data;

  rv_alu u_alu (
    .op           (dec.alu_op),
    .a            (rs1_data),
    .b            (alu_b),
    .branch       (dec.branch),
    .result       (alu_result),
    .branch_taken (branch_taken)
  );

  // write-back for the coming edge, quiet during reset
  assign wb.we = dec.reg_we && !dec.is_branch && !rst;
  assign wb.rd = dec.rd;
  assign wb.data = alu_result;

  assign halt = dec.is_ecall && !rst;

  // branch target is relative to the branch itself
  assign pc_next = (dec.is_branch && branch_taken) ? pc + dec.imm : pc + INSN_STEP;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  // a taken branch with a bad offset would show up here
  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("rv_core: misaligned pc %h", pc);

endmodule

/* verilog/rv_regfile.sv */
`timescale 1ns/10ps
`include "rv_core_config.svh"

module rv_regfile
  import rv_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  wb_t                   wb,
  input  logic [`RV_REG_AW-1:0] rs1,
  input  logic [`RV_REG_AW-1:0] rs2,
  output logic [`RV_XLEN-1:0]   rs1_data,
  output logic [`RV_XLEN-1:0]   rs2_data
);

  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      regs <= '{default: '0};
    end else if (wb.we && (wb.rd != '0)) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // x0 reads as zero because entry 0 is cleared and never written
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // x0 storage must stay clear whatever the core writes back
  a_x0_zero: assert property (@(posedge clk) disable iff (rst) regs[0] == '0)
    else $error("rv_regfile: x0 storage was written");

endmodule

/* verilog/rv_alu.sv */
`timescale 1ns/10ps
`include "rv_core_config.svh"

module rv_alu
  import rv_pkg::*;
(
  input  alu_op_e             op,
  input  logic [`RV_XLEN-1:0] a,
  input  logic [`RV_XLEN-1:0] b,
  input  branch_e             branch,
  output logic [`RV_XLEN-1:0] result,
  output logic                branch_taken
);

  logic [4:0] shamt;
  logic       eq;
  logic       lt;
  logic       ltu;

  // only the low 5 bits of the shift amount count
  assign shamt = b[4:0];

  // compares are shared between SLT/SLTU and the branch unit
  assign eq = (a == b);
  assign lt = ($signed(a) < $signed(b));
  assign ltu = (a < b);

  always_comb begin
    // op comes straight from decode, anything outside the enum is a decode bug
    assert (op inside {ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
                       ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B})
      else $error("rv_alu: undefined operation %0d", op);
    case (op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_SLL:    result = a << shamt;
      ALU_SLT:    result = {{(`RV_XLEN-1){1'b0}}, lt};
      ALU_SLTU:   result = {{(`RV_XLEN-1){1'b0}}, ltu};
      ALU_XOR:    result = a ^ b;
      ALU_SRL:    result = a >> shamt;
      ALU_SRA:    result = $signed(a) >>> shamt;
      ALU_OR:     result = a | b;
      ALU_AND:    result = a & b;
      ALU_PASS_B: result = b;
      default:    result = '0;
    endcase
  end

  always_comb begin
    case (branch)
      BR_BEQ:  branch_taken = eq;
      BR_BNE:  branch_taken = !eq;
      BR_BLT:  branch_taken = lt;
      BR_BGE:  branch_taken = !lt;
      BR_BLTU: branch_taken = ltu;
      BR_BGEU: branch_taken = !ltu;
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

/* verilog/rv_decode.sv */
`timescale 1ns/10ps
`include "rv_core_config.svh"

module rv_decode
  import rv_pkg::*;
(
  input  logic [31:0] insn,
  output decoded_t    dec
);

  opcode_e             opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;

  assign opcode = opcode_e'(insn[6:0]);
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  // sign-extended immediates
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  // U type sits in the upper 20 bits
  assign imm_u = {insn[31:12], 12'b0};

  // alt picks SUB for funct3 000 and SRA for funct3 101
  function automatic alu_op_e funct3_to_op(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000: op = alt ? ALU_SUB : ALU_ADD;
      3'b001: op = ALU_SLL;
      3'b010: op = ALU_SLT;
      3'b011: op = ALU_SLTU;
      3'b100: op = ALU_XOR;
      3'b101: op = alt ? ALU_SRA : ALU_SRL;
      3'b110: op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    dec = '0;
    dec.rs1 = insn[19:15];
    dec.rs2 = insn[24:20];
    dec.rd = insn[11:7];
    case (opcode)
      OPC_LUI: begin
        dec.alu_op = ALU_PASS_B;
        dec.use_imm = 1'b1;
        dec.imm = imm_u;
        dec.reg_we = 1'b1;
      end
      OPC_OP_IMM: begin
        // ADDI has no SUB form, only the right shift looks at funct7
        dec.alu_op = funct3_to_op(funct3, (funct3 == 3'b101) && funct7[5]);
        dec.use_imm = 1'b1;
        dec.imm = imm_i;
        case (funct3)
          3'b001: dec.reg_we = (funct7 == 7'b0000000);
          3'b101: dec.reg_we = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
          default: dec.reg_we = 1'b1;
        endcase
      end
      OPC_OP: begin
        dec.alu_op = funct3_to_op(funct3, funct7[5]);
        // M extension (funct7 = 1) and other encodings write nothing
        dec.reg_we = (funct7 == 7'b0000000) ||
                     ((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      OPC_BRANCH: begin
        // funct3 010 and 011 are reserved
        dec.is_branch = (funct3[2:1] != 2'b01);
        dec.branch = branch_e'(funct3);
        dec.imm = imm_b;
      end
      OPC_SYSTEM: begin
        dec.is_ecall = (insn[31:7] == 25'd0);
      end
      OPC_LOAD, OPC_STORE, OPC_JAL, OPC_JALR, OPC_AUIPC, OPC_MISC_MEM: begin
        // not implemented here, treated as a no-op
        dec.reg_we = 1'b0;
      end
      default: begin
        dec.reg_we = 1'b0;
      end
    endcase
  end

endmodule

/* verilog/rv_pkg.sv */
`include "rv_core_config.svh"

package rv_pkg;

  // major opcodes, the unimplemented ones are listed so decode can ignore them
  typedef enum logic [6:0] {
    OPC_LOAD     = 7'b0000011,
    OPC_MISC_MEM = 7'b0001111,
    OPC_OP_IMM   = 7'b0010011,
    OPC_AUIPC    = 7'b0010111,
    OPC_STORE    = 7'b0100011,
    OPC_OP       = 7'b0110011,
    OPC_LUI      = 7'b0110111,
    OPC_BRANCH   = 7'b1100011,
    OPC_JALR     = 7'b1100111,
    OPC_JAL      = 7'b1101111,
    OPC_SYSTEM   = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  // values are the funct3 codes of the branch group
  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } branch_e;

  typedef struct packed {
    logic [`RV_REG_AW-1:0] rs1;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rd;
    alu_op_e               alu_op;
    logic                  use_imm;
    logic [`RV_XLEN-1:0]   imm;
    logic                  reg_we;
    logic                  is_branch;
    branch_e               branch;
    logic                  is_ecall;
  } decoded_t;

  typedef struct packed {
    logic                  we;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   data;
  } wb_t;

endpackage

/* include/rv_core_config.svh */
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// data path and address width
`define RV_XLEN 32

// architectural register file
`define RV_NUM_REGS 32
`define RV_REG_AW 5

// fetch starts here once reset drops
`define RV_RESET_PC 0
`define RV_INSN_BYTES 4

`endif
